// File: sources.f
+incdir+.
rob_pkg.sv
rob_entry_ram.sv
rob_alloc.sv
rob_status.sv
rob_commit_select.sv
rob_redirect.sv
rob_top.sv
tb_rob.sv

// File: run.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rob -f sources.f \
    -o sim_rob > build.log 2>&1 \
    && ./obj_dir/sim_rob > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_rob_model.svh
`ifndef TB_ROB_MODEL_SVH
`define TB_ROB_MODEL_SVH

// one accepted entry as the dispatch stage sees it
typedef struct {
    logic [rob_pkg::opid_bits-1:0] opid;
    rob_pkg::addr_t                pc;
    logic [2:0]                    delta;
    rob_pkg::red_kind_e            kind;      // chosen outcome
    rob_pkg::cause_t               cause;
    rob_pkg::addr_t                npc;
    rob_pkg::addr_t                tval;
    bit                            completed;
} entry_t;

entry_t exp_q[$]; // dispatch order, oldest first

// completion bundle for an entry and its chosen outcome
function automatic rob_pkg::comp_t make_comp(entry_t e);
    rob_pkg::comp_t c;
    c       = '0;
    c.valid = 1'b1;
    c.opid  = e.opid;
    c.exc   = (e.kind == rob_pkg::red_exception);
    c.retry = (e.kind == rob_pkg::red_retry);
    c.flush = (e.kind == rob_pkg::red_flush);
    c.misp  = (e.kind == rob_pkg::red_mispredict);
    c.cause = e.cause;
    c.npc   = e.npc;
    c.tval  = e.tval;
    return c;
endfunction

// expected redirect bundle for the entry that raised it
function automatic rob_pkg::redirect_t expect_redirect(entry_t e, rob_pkg::addr_t tv);
    rob_pkg::redirect_t r;
    r      = '0;
    r.kind = e.kind;
    r.opid = e.opid;
    case (e.kind)
        rob_pkg::red_exception: begin
            r.npc   = tv;
            r.epc   = e.pc;
            r.cause = e.cause;
            r.tval  = e.tval;
        end
        rob_pkg::red_flush:      r.npc = e.pc + 32'(e.delta); // next insn
        rob_pkg::red_retry:      r.npc = e.pc;
        rob_pkg::red_mispredict: r.npc = e.npc & ~32'h1;
        default:                 r.npc = e.pc;
    endcase
    return r;
endfunction

`endif

// File: tb_rob.sv
`default_nettype none

module tb_rob;

    `include "tb_rob_model.svh"

    logic                                clk;
    logic                                rst;
    rob_pkg::disp_t [1:0]                dispatch;
    logic                                disp_ready;
    rob_pkg::disp_id_t [1:0]             disp_ids;
    rob_pkg::comp_t [1:0]                comp;
    rob_pkg::addr_t                      tvec;
    rob_pkg::commit_t [1:0]              commit;
    rob_pkg::redirect_t                  redirect;
    logic                                redirect_valid;

    int      value_errs;
    int      other_errs;
    int      next_id;      // expected next opid
    int      redirects;
    bit      ev_pending;   // flush or mispredict head committed, redirect due
    entry_t  ev_entry;
    entry_t  ce;
    rob_pkg::redirect_t exp_red;

    rob_top #(
        .rob_depth(16), .disp_width(2), .comp_width(2), .com_width(2)
    ) rob_top_inst (
        .clk(clk), .rst(rst), .dispatch(dispatch), .disp_ready(disp_ready),
        .disp_ids(disp_ids), .comp(comp), .tvec(tvec), .commit(commit),
        .redirect(redirect), .redirect_valid(redirect_valid)
    );

    always #10 clk = ~clk;

    // compares commits and redirects against the model
    always @(negedge clk) begin
        if (!rst) begin
            assert (!ev_pending || redirect_valid) else begin
                $display("no redirect in the cycle after a flush or mispredict commit");
                other_errs++;
                ev_pending = 0;
            end
            for (int i = 0; i < 2; i++) begin
                if (commit[i].valid) begin
                    if (ev_pending || exp_q.size() == 0) begin
                        $display("commit lane %0d valid with no entry allowed to commit", i);
                        other_errs++;
                    end else begin
                        ce = exp_q.pop_front();
                        assert (commit[i].opid == ce.opid) else begin
                            $display("Error: commit[%0d].opid got %h expected %h",
                                     i, commit[i].opid, ce.opid);
                            value_errs++;
                        end
                        assert (commit[i].pc == ce.pc) else begin
                            $display("Error: commit[%0d].pc got %h expected %h",
                                     i, commit[i].pc, ce.pc);
                            value_errs++;
                        end
                        assert (ce.completed) else begin
                            $display("entry %0d committed before it completed", ce.opid);
                            other_errs++;
                        end
                        assert (ce.kind != rob_pkg::red_exception
                                && ce.kind != rob_pkg::red_retry) else begin
                            $display("entry %0d committed despite exception or retry", ce.opid);
                            other_errs++;
                        end
                        if (ce.kind == rob_pkg::red_flush
                            || ce.kind == rob_pkg::red_mispredict) begin
                            ev_entry   = ce;
                            ev_pending = 1; // younger lanes must stay idle
                        end
                    end
                end
            end
            if (redirect_valid) begin
                if (ev_pending || exp_q.size() != 0) begin
                    ce      = ev_pending ? ev_entry : exp_q[0];
                    exp_red = expect_redirect(ce, tvec);
                    assert (redirect == exp_red) else begin
                        $display("Error: redirect got %h expected %h", redirect, exp_red);
                        value_errs++;
                    end
                    assert (ev_pending || (ce.kind != rob_pkg::red_flush
                                           && ce.kind != rob_pkg::red_mispredict)) else begin
                        $display("entry %0d redirected without committing", ce.opid);
                        other_errs++;
                    end
                end else begin
                    $display("redirect raised with no entry in flight");
                    other_errs++;
                end
                exp_q.delete(); // buffer empties
                ev_pending = 0;
                next_id    = 0;
                redirects++;
            end
        end
    end

    function automatic entry_t make_entry(rob_pkg::red_kind_e k);
        entry_t e;
        e.opid      = '0;
        e.pc        = $urandom & 32'hffff_fffe;
        e.delta     = ($urandom % 2) ? 3'd4 : 3'd2;
        e.kind      = k;
        e.cause     = 5'($urandom);
        e.npc       = $urandom; // bit 0 left random
        e.tval      = $urandom;
        e.completed = 0;
        return e;
    endfunction

    // holds n lanes until accepted or max_wait cycles pass
    task automatic send(input entry_t a, input entry_t b, input int n,
                        input int max_wait, output bit taken);
        int     waited;
        entry_t lanes [2];
        lanes[0] = a;
        lanes[1] = b;
        taken    = 0;
        waited   = 0;
        for (int i = 0; i < 2; i++) begin
            dispatch[i].valid = (i < n);
            dispatch[i].pc    = lanes[i].pc;
            dispatch[i].delta = lanes[i].delta;
        end
        while (!taken && waited < max_wait) begin
            @(negedge clk);
            if (disp_ready) begin
                for (int i = 0; i < n; i++) begin
                    assert (disp_ids[i].valid && disp_ids[i].opid == 6'(next_id)) else begin
                        $display("Error: disp_ids[%0d] got %h expected %h",
                                 i, disp_ids[i], {1'b1, 6'(next_id)});
                        value_errs++;
                    end
                    lanes[i].opid = disp_ids[i].opid;
                    exp_q.push_back(lanes[i]);
                    next_id = (next_id + 1) % 16;
                end
                for (int i = n; i < 2; i++) begin
                    assert (!disp_ids[i].valid) else begin
                        $display("Error: disp_ids[%0d].valid got %h expected %h",
                                 i, disp_ids[i].valid, 1'b0);
                        value_errs++;
                    end
                end
                taken = 1;
            end
            @(posedge clk);
            #2;
            waited++;
        end
        dispatch = '0;
    endtask

    task automatic send_ok(input entry_t a, input entry_t b, input int n);
        bit taken;
        send(a, b, n, 50, taken);
        if (!taken) begin
            $display("timeout waiting for disp_ready");
            other_errs++;
        end
    endtask

    // completes queue entries ia and ib (ib < 0 for one lane)
    task automatic complete(input int ia, input int ib);
        comp[0] = make_comp(exp_q[ia]);
        exp_q[ia].completed = 1;
        if (ib >= 0) begin
            comp[1] = make_comp(exp_q[ib]);
            exp_q[ib].completed = 1;
        end
        @(posedge clk);
        #2;
        comp = '0;
    endtask

    task automatic complete_random();
        int pend[$];
        int k;
        int a;
        forever begin
            pend.delete();
            foreach (exp_q[i]) if (!exp_q[i].completed) pend.push_back(i);
            if (pend.size() == 0) break;
            k = $urandom % pend.size();
            a = pend[k];
            pend.delete(k);
            if (pend.size() != 0 && ($urandom % 2)) complete(a, pend[$urandom % pend.size()]);
            else complete(a, -1);
        end
    endtask

    task automatic wait_drain();
        int w;
        w = 0;
        while (exp_q.size() != 0 && w < 100) begin
            @(posedge clk);
            w++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for the buffer to drain");
            other_errs++;
        end
        #2;
    endtask

    task automatic event_case(input rob_pkg::red_kind_e k);
        int target;
        int w;
        send_ok(make_entry(rob_pkg::red_none), make_entry(k), 2);
        send_ok(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 2);
        for (int i = 3; i >= 0; i--) complete(i, -1); // head completes last
        target = redirects + 1;
        w      = 0;
        while (redirects < target && w < 50) begin
            @(posedge clk);
            w++;
        end
        if (redirects < target) begin
            $display("timeout waiting for redirect_valid");
            other_errs++;
        end
        #2;
        // ids restart at 0 after the redirect
        send_ok(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 1);
        complete(0, -1);
        wait_drain();
    endtask

    initial begin
        bit taken;
        void'($urandom(42));
        clk        = 0;
        rst        = 1;
        dispatch   = '0;
        comp       = '0;
        tvec       = 32'h8000_0100;
        value_errs = 0;
        other_errs = 0;
        next_id    = 0;
        redirects  = 0;
        ev_pending = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 0;
        @(negedge clk);
        assert (disp_ready && !commit[0].valid && !commit[1].valid && !redirect_valid)
        else begin
            $display("outputs not idle after reset");
            other_errs++;
        end
        @(posedge clk);
        #2;
        // in-order commit with random completion
        for (int i = 0; i < 5; i++) begin
            send_ok(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 2);
        end
        complete_random();
        wait_drain();
        // leave one free entry with no completions
        for (int i = 0; i < 7; i++) begin
            send_ok(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 2);
        end
        send_ok(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 1);
        send(make_entry(rob_pkg::red_none), make_entry(rob_pkg::red_none), 2, 4, taken);
        if (taken || exp_q.size() != 15) begin
            $display("disp_ready stayed high with fewer free entries than lanes");
            other_errs++;
        end
        complete_random();
        wait_drain();
        event_case(rob_pkg::red_exception);
        event_case(rob_pkg::red_retry);
        event_case(rob_pkg::red_flush);
        event_case(rob_pkg::red_mispredict);
        repeat (5) @(posedge clk);
        $display("errors: value %0d, other %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob_top.sv
`default_nettype none

module rob_top #(
    parameter int rob_depth  = 16,
    parameter int disp_width = 2,
    parameter int comp_width = 2,
    parameter int com_width  = 2,
    localparam int aw        = $clog2(rob_depth),
    localparam int cw        = $clog2(com_width + 1)
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  rob_pkg::disp_t [disp_width-1:0] dispatch,
    output logic                                  disp_ready,
    output rob_pkg::disp_id_t [disp_width-1:0]    disp_ids,
    input  wire  rob_pkg::comp_t [comp_width-1:0] comp,
    input  wire  rob_pkg::addr_t                  tvec,
    output rob_pkg::commit_t [com_width-1:0]      commit,
    output rob_pkg::redirect_t                    redirect,
    output logic                                  redirect_valid
);

    logic [aw-1:0]                     front;
    logic [aw:0]                       count;
    logic [disp_width-1:0][aw-1:0]     info_waddr;
    rob_pkg::info_t [disp_width-1:0]   info_wdata;
    logic [disp_width-1:0]             info_wena;
    logic [disp_width-1:0][aw-1:0]     alloc_ids;
    logic [disp_width-1:0]             alloc_ena;
    logic [rob_depth-1:0]              done;
    logic [com_width-1:0][aw-1:0]      raddr;
    rob_pkg::info_t [com_width-1:0]    info_rdata;
    rob_pkg::result_t [com_width-1:0]  result_rdata;
    logic [comp_width-1:0][aw-1:0]     result_waddr;
    rob_pkg::result_t [comp_width-1:0] result_wdata;
    logic [comp_width-1:0]             result_wena;
    logic [cw-1:0]                     com_count;
    logic                              head_event;
    rob_pkg::red_kind_e                head_kind;
    logic [rob_pkg::opid_bits-1:0]     head_opid;
    rob_pkg::info_t                    head_info;
    rob_pkg::result_t                  head_result;
    logic                              flush;

    // completion lanes feed the result bank directly
    for (genvar i = 0; i < comp_width; i++) begin : g_comp
        assign result_waddr[i]       = comp[i].opid[aw-1:0];
        assign result_wena[i]        = comp[i].valid;
        assign result_wdata[i].exc   = comp[i].exc;
        assign result_wdata[i].cause = comp[i].cause;
        assign result_wdata[i].flush = comp[i].flush;
        assign result_wdata[i].retry = comp[i].retry;
        assign result_wdata[i].misp  = comp[i].misp;
        assign result_wdata[i].npc   = comp[i].npc;
        assign result_wdata[i].tval  = comp[i].tval;
    end

    rob_alloc #(
        .rob_depth(rob_depth), .disp_width(disp_width), .com_width(com_width)
    ) alloc_inst (
        .clk(clk), .rst(rst), .dispatch(dispatch), .flush(flush),
        .com_count(com_count), .head_event(head_event),
        .disp_ready(disp_ready), .disp_ids(disp_ids), .front(front), .count(count),
        .info_waddr(info_waddr), .info_wdata(info_wdata), .info_wena(info_wena),
        .alloc_ids(alloc_ids), .alloc_ena(alloc_ena)
    );

    rob_status #(
        .rob_depth(rob_depth), .disp_width(disp_width), .comp_width(comp_width)
    ) status_inst (
        .clk(clk), .rst(rst), .alloc_ids(alloc_ids), .alloc_ena(alloc_ena),
        .comp(comp), .flush(flush), .done(done)
    );

    rob_entry_ram #(
        .width($bits(rob_pkg::info_t)), .depth(rob_depth),
        .wports(disp_width), .rports(com_width)
    ) info_ram_inst (
        .clk(clk), .rst(rst), .waddr(info_waddr), .wdata(info_wdata),
        .wena(info_wena), .raddr(raddr), .rdata(info_rdata)
    );

    rob_entry_ram #(
        .width($bits(rob_pkg::result_t)), .depth(rob_depth),
        .wports(comp_width), .rports(com_width)
    ) result_ram_inst (
        .clk(clk), .rst(rst), .waddr(result_waddr), .wdata(result_wdata),
        .wena(result_wena), .raddr(raddr), .rdata(result_rdata)
    );

    rob_commit_select #(
        .rob_depth(rob_depth), .com_width(com_width)
    ) commit_select_inst (
        .front(front), .count(count), .done(done),
        .info_rdata(info_rdata), .result_rdata(result_rdata), .raddr(raddr),
        .commit(commit), .com_count(com_count), .head_event(head_event),
        .head_kind(head_kind), .head_opid(head_opid),
        .head_info(head_info), .head_result(head_result)
    );

    rob_redirect redirect_inst (
        .clk(clk), .rst(rst), .head_event(head_event), .head_kind(head_kind),
        .head_opid(head_opid), .head_info(head_info), .head_result(head_result),
        .tvec(tvec), .redirect(redirect), .redirect_valid(redirect_valid),
        .flush(flush)
    );

endmodule

`default_nettype wire

// File: rob_redirect.sv
`default_nettype none

module rob_redirect (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  head_event,
    input  wire  rob_pkg::red_kind_e             head_kind,
    input  wire  [rob_pkg::opid_bits-1:0]        head_opid,
    input  wire  rob_pkg::info_t                 head_info,
    input  wire  rob_pkg::result_t               head_result,
    input  wire  rob_pkg::addr_t                 tvec,
    output rob_pkg::redirect_t                   redirect,
    output logic                                 redirect_valid,
    output logic                                 flush
);

    rob_pkg::redirect_t red_next;

    always_comb begin
        red_next       = '0;
        red_next.kind  = head_event ? head_kind : rob_pkg::red_none;
        red_next.opid  = head_opid;
        case (head_kind)
            rob_pkg::red_exception: begin
                red_next.npc   = tvec;
                red_next.epc   = head_info.pc;
                red_next.cause = head_result.cause;
                red_next.tval  = head_result.tval;
            end
            rob_pkg::red_flush: begin
                red_next.npc = head_info.pc + rob_pkg::addr_t'(head_info.delta); // next insn
            end
            rob_pkg::red_retry: begin
                red_next.npc = head_info.pc;
            end
            rob_pkg::red_mispredict: begin
                red_next.npc = {head_result.npc[31:1], 1'b0}; // keep fetch aligned
            end
            default: begin
                red_next.npc = head_info.pc;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= head_event; // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        redirect <= red_next;
    end

    assign flush = redirect_valid;

endmodule

`default_nettype wire

// File: rob_commit_select.sv
`default_nettype none

module rob_commit_select #(
    parameter int rob_depth = 16,
    parameter int com_width = 2,
    localparam int aw       = $clog2(rob_depth),
    localparam int cw       = $clog2(com_width + 1)
) (
    input  wire  [aw-1:0]                           front,
    input  wire  [aw:0]                             count,
    input  wire  [rob_depth-1:0]                    done,
    input  wire  rob_pkg::info_t [com_width-1:0]    info_rdata,
    input  wire  rob_pkg::result_t [com_width-1:0]  result_rdata,
    output logic [com_width-1:0][aw-1:0]            raddr,
    output rob_pkg::commit_t [com_width-1:0]        commit,
    output logic [cw-1:0]                           com_count,
    output logic                                    head_event,
    output rob_pkg::red_kind_e                      head_kind,
    output logic [rob_pkg::opid_bits-1:0]           head_opid,
    output rob_pkg::info_t                          head_info,
    output rob_pkg::result_t                        head_result
);

    logic [com_width-1:0] ready; // present, done and event free

    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            raddr[i] = front + aw'(i);
            ready[i] = ((aw + 1)'(i) < count) && done[raddr[i]]
                       && !result_rdata[i].exc && !result_rdata[i].retry
                       && !result_rdata[i].flush && !result_rdata[i].misp;
        end
    end

    // head event, exception first
    always_comb begin
        if (result_rdata[0].exc) begin
            head_kind = rob_pkg::red_exception;
        end else if (result_rdata[0].retry) begin
            head_kind = rob_pkg::red_retry;
        end else if (result_rdata[0].flush) begin
            head_kind = rob_pkg::red_flush;
        end else if (result_rdata[0].misp) begin
            head_kind = rob_pkg::red_mispredict;
        end else begin
            head_kind = rob_pkg::red_none;
        end
        head_event = (count != '0) && done[raddr[0]] && (head_kind != rob_pkg::red_none);
    end

    assign head_opid   = rob_pkg::opid_bits'(front);
    assign head_info   = info_rdata[0];
    assign head_result = result_rdata[0];

    always_comb begin
        logic go;
        logic [cw-1:0] n;
        go = 1'b1;
        n  = '0;
        for (int i = 0; i < com_width; i++) begin
            commit[i].opid  = rob_pkg::opid_bits'(raddr[i]);
            commit[i].pc    = info_rdata[i].pc;
            commit[i].valid = go && ready[i]; // in-order prefix only
            if (commit[i].valid) begin
                n = n + 1'b1;
            end else begin
                go = 1'b0;
            end
        end
        // flush and mispredict still retire the head itself
        if (head_event && (head_kind == rob_pkg::red_flush
                           || head_kind == rob_pkg::red_mispredict)) begin
            commit[0].valid = 1'b1;
            n = cw'(1);
        end
        com_count = n;
    end

endmodule

`default_nettype wire

// File: rob_status.sv
`default_nettype none

module rob_status #(
    parameter int rob_depth  = 16,
    parameter int disp_width = 2,
    parameter int comp_width = 2,
    localparam int aw        = $clog2(rob_depth)
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [disp_width-1:0][aw-1:0]         alloc_ids,
    input  wire  [disp_width-1:0]                 alloc_ena,
    input  wire  rob_pkg::comp_t [comp_width-1:0] comp,
    input  wire                                   flush,
    output logic [rob_depth-1:0]                  done
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            done <= '0;
        end else begin
            for (int i = 0; i < comp_width; i++) begin
                if (comp[i].valid) begin
                    done[comp[i].opid[aw-1:0]] <= 1'b1;
                end
            end
            // allocation comes last so it wins on a collision
            for (int i = 0; i < disp_width; i++) begin
                if (alloc_ena[i]) begin
                    done[alloc_ids[i]] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rob_alloc.sv
`default_nettype none

module rob_alloc #(
    parameter int rob_depth  = 16,
    parameter int disp_width = 2,
    parameter int com_width  = 2,
    localparam int aw        = $clog2(rob_depth),
    localparam int cw        = $clog2(com_width + 1),
    localparam int iw        = $clog2(disp_width + 1)
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  rob_pkg::disp_t [disp_width-1:0]    dispatch,
    input  wire                                      flush,
    input  wire  [cw-1:0]                            com_count,
    input  wire                                      head_event,
    output logic                                     disp_ready,
    output rob_pkg::disp_id_t [disp_width-1:0]       disp_ids,
    output logic [aw-1:0]                            front,
    output logic [aw:0]                              count,
    output logic [disp_width-1:0][aw-1:0]            info_waddr,
    output rob_pkg::info_t [disp_width-1:0]          info_wdata,
    output logic [disp_width-1:0]                    info_wena,
    output logic [disp_width-1:0][aw-1:0]            alloc_ids,
    output logic [disp_width-1:0]                    alloc_ena
);

    logic [aw-1:0] tail;
    logic [aw:0]   free;
    logic [iw-1:0] in_count; // lanes accepted this cycle

    assign free = (aw + 1)'(rob_depth) - count;

    // hold off while the head redirects or the redirect drains
    assign disp_ready = (free >= (aw + 1)'(disp_width)) && !head_event && !flush;

    always_comb begin
        logic [iw-1:0] idx;
        idx = '0;
        for (int i = 0; i < disp_width; i++) begin
            alloc_ena[i]        = dispatch[i].valid && disp_ready;
            alloc_ids[i]        = tail + aw'(idx);
            info_waddr[i]       = alloc_ids[i];
            info_wena[i]        = alloc_ena[i];
            info_wdata[i].pc    = dispatch[i].pc;
            info_wdata[i].delta = dispatch[i].delta;
            disp_ids[i].valid   = alloc_ena[i];
            disp_ids[i].opid    = rob_pkg::opid_bits'(alloc_ids[i]);
            if (alloc_ena[i]) begin
                idx = idx + 1'b1;
            end
        end
        in_count = idx;
    end

    always_ff @(posedge clk) begin
        if (rst || head_event || flush) begin
            front <= '0; // buffer empties on a redirect
            tail  <= '0;
            count <= '0;
        end else begin
            front <= front + aw'(com_count);
            tail  <= tail + aw'(in_count);
            count <= count + (aw + 1)'(in_count) - (aw + 1)'(com_count);
        end
    end

endmodule

`default_nettype wire

// File: rob_entry_ram.sv
`default_nettype none

module rob_entry_ram #(
    parameter int width  = 32,
    parameter int depth  = 16,
    parameter int wports = 2,
    parameter int rports = 2
) (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  [wports-1:0][$clog2(depth)-1:0]       waddr,
    input  wire  [wports-1:0][width-1:0]               wdata,
    input  wire  [wports-1:0]                          wena,
    input  wire  [rports-1:0][$clog2(depth)-1:0]       raddr,
    output logic [rports-1:0][width-1:0]               rdata
);

    logic [width-1:0] mem [depth];

    // later lanes overwrite earlier ones on the same address
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < wports; i++) begin
                if (wena[i]) begin
                    mem[waddr[i]] <= wdata[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rports; i++) begin
            rdata[i] = mem[raddr[i]]; // async read
        end
    end

endmodule

`default_nettype wire

// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

    localparam int opid_bits = 6; // enough for 64 entries

    typedef logic [31:0] addr_t;
    typedef logic [4:0]  cause_t;

    typedef enum logic [2:0] {
        red_none,
        red_exception,
        red_flush,
        red_retry,
        red_mispredict
    } red_kind_e;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        logic [2:0] delta; // instruction length in bytes
    } disp_t;

    typedef struct packed {
        logic                 valid;
        logic [opid_bits-1:0] opid;
    } disp_id_t;

    typedef struct packed {
        addr_t      pc;
        logic [2:0] delta;
    } info_t;

    typedef struct packed {
        logic                 valid;
        logic [opid_bits-1:0] opid;
        logic                 exc;   // exception raised
        cause_t               cause;
        logic                 flush; // refetch from next pc
        logic                 retry; // refetch same pc
        logic                 misp;  // branch mispredicted
        addr_t                npc;   // resolved target
        addr_t                tval;
    } comp_t;

    // completion payload as kept per entry
    typedef struct packed {
        logic   exc;
        cause_t cause;
        logic   flush;
        logic   retry;
        logic   misp;
        addr_t  npc;
        addr_t  tval;
    } result_t;

    typedef struct packed {
        logic                 valid;
        logic [opid_bits-1:0] opid;
        addr_t                pc;
    } commit_t;

    typedef struct packed {
        red_kind_e            kind;
        logic [opid_bits-1:0] opid;
        addr_t                npc;
        addr_t                epc;
        cause_t               cause;
        addr_t                tval;
    } redirect_t;

endpackage

`default_nettype wire
